/* hw/isa_pkg.sv */
package isa_pkg;

  localparam int xlen  = 32;  // data and address width
  localparam int nregs = 32;  // general purpose registers

  typedef logic [xlen-1:0]          word_t;
  typedef logic [$clog2(nregs)-1:0] reg_addr_t;

  localparam reg_addr_t reg_ra = reg_addr_t'(31);  // jal link target

  // major opcodes in inst[31:26]
  typedef enum logic [5:0] {
    op_special = 6'b000000,  // r-type, see funct
    op_j       = 6'b000010,
    op_jal     = 6'b000011,
    op_beq     = 6'b000100,
    op_bne     = 6'b000101,
    op_addi    = 6'b001000,
    op_andi    = 6'b001100,
    op_ori     = 6'b001101,
    op_xori    = 6'b001110,
    op_cop0    = 6'b010000,  // mfc0 mtc0 eret
    op_lw      = 6'b100011,
    op_sw      = 6'b101011
  } opcode_e;

  // funct field of special ops
  typedef enum logic [5:0] {
    fn_jr      = 6'b001000,
    fn_syscall = 6'b001100,
    eret_funct = 6'b011000,  // only valid under cop0 co
    fn_add     = 6'b100000,
    fn_sub     = 6'b100010,
    fn_and     = 6'b100100,
    fn_or      = 6'b100101,
    fn_xor     = 6'b100110
  } funct_e;

  // rs field of cop0 ops
  typedef enum logic [4:0] {
    c0_mf = 5'b00000,
    c0_mt = 5'b00100,
    c0_co = 5'b10000
  } cop0_rs_e;

  // imm is the low 16 bits, jump target the low 26
  typedef struct packed {
    logic [5:0] op;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } instr_t;

  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;
  typedef enum logic [1:0] {pc_seq, pc_branch, pc_reg, pc_jump} pc_src_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link, wb_cp0} wb_src_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_imm;  // b operand from immediate
    logic    sext;     // sign extend immediate
    logic    dest_rt;  // write rt instead of rd
    logic    wreg;
    logic    wmem;
    wb_src_e wb_src;
    pc_src_e pc_src;
  } ctrl_t;

endpackage

/* hw/cp0_pkg.sv */
package cp0_pkg;

  // cp0 register numbers, taken from rd
  typedef enum logic [4:0] {
    creg_status = 5'd12,
    creg_cause  = 5'd13,
    creg_epc    = 5'd14
  } cp0_reg_e;

  // exccode, stored in cause[3:2]
  typedef enum logic [1:0] {
    exc_intr    = 2'd0,
    exc_syscall = 2'd1,
    exc_unimpl  = 2'd2,
    exc_ovf     = 2'd3
  } exc_code_e;

  localparam int status_bit_intr    = 0;  // enable bits, same order as codes
  localparam int status_bit_syscall = 1;
  localparam int status_bit_unimpl  = 2;
  localparam int status_bit_ovf     = 3;
  localparam int status_shift       = 4;  // status stack step
  localparam int cause_code_lsb     = 2;

  localparam logic [31:0] exc_vector = 32'h8;  // handler entry

  typedef enum logic [1:0] {sel_next, sel_epc, sel_vector} pc_sel_e;

  typedef struct packed {
    logic       syscall;
    logic       unimpl;  // pattern outside the kept set
    logic       arith;   // add/sub/addi, overflow counts
    logic       eret;
    logic       mtc0;
    logic       mfc0;
    logic [4:0] c0_reg;
  } exc_req_t;

endpackage

/* hw/decoder.sv */
`timescale 1ns/1ns

module decoder (
  input  isa_pkg::instr_t    i_inst,
  input  logic               i_zero,     // alu result is zero
  output isa_pkg::ctrl_t     o_ctrl,
  output cp0_pkg::exc_req_t  o_exc_req
);
  import isa_pkg::*;

  always_comb begin
    o_ctrl           = '0;
    o_ctrl.alu_op    = alu_add;
    o_ctrl.wb_src    = wb_alu;
    o_ctrl.pc_src    = pc_seq;
    o_exc_req        = '0;
    o_exc_req.c0_reg = i_inst.rd;  // cp0 reg number lives in rd
    case (i_inst.op)
      op_special: begin
        case (i_inst.funct)
          fn_add: begin
            o_ctrl.wreg     = 1'b1;
            o_exc_req.arith = 1'b1;
          end
          fn_sub: begin
            o_ctrl.alu_op   = alu_sub;
            o_ctrl.wreg     = 1'b1;
            o_exc_req.arith = 1'b1;
          end
          fn_and: begin
            o_ctrl.alu_op = alu_and;
            o_ctrl.wreg   = 1'b1;
          end
          fn_or: begin
            o_ctrl.alu_op = alu_or;
            o_ctrl.wreg   = 1'b1;
          end
          fn_xor: begin
            o_ctrl.alu_op = alu_xor;
            o_ctrl.wreg   = 1'b1;
          end
          fn_jr:      o_ctrl.pc_src = pc_reg;  // target from rs
          fn_syscall: o_exc_req.syscall = 1'b1;
          default:    o_exc_req.unimpl = 1'b1;  // shifts, div, mult, ...
        endcase
      end
      op_addi: begin
        o_ctrl.alu_imm  = 1'b1;
        o_ctrl.sext     = 1'b1;
        o_ctrl.dest_rt  = 1'b1;
        o_ctrl.wreg     = 1'b1;
        o_exc_req.arith = 1'b1;
      end
      op_andi, op_ori, op_xori: begin
        // logic immediates are zero extended
        o_ctrl.alu_op  = (i_inst.op == op_andi) ? alu_and :
                         (i_inst.op == op_ori)  ? alu_or  : alu_xor;
        o_ctrl.alu_imm = 1'b1;
        o_ctrl.dest_rt = 1'b1;
        o_ctrl.wreg    = 1'b1;
      end
      op_lw: begin
        o_ctrl.alu_imm = 1'b1;  // address = rs + simm
        o_ctrl.sext    = 1'b1;
        o_ctrl.dest_rt = 1'b1;
        o_ctrl.wreg    = 1'b1;
        o_ctrl.wb_src  = wb_mem;
      end
      op_sw: begin
        o_ctrl.alu_imm = 1'b1;
        o_ctrl.sext    = 1'b1;
        o_ctrl.wmem    = 1'b1;
      end
      op_beq, op_bne: begin
        o_ctrl.alu_op = alu_xor;  // zero when rs == rt
        o_ctrl.sext   = 1'b1;     // offset is signed
        if ((i_inst.op == op_beq) == i_zero)
          o_ctrl.pc_src = pc_branch;
      end
      op_j: o_ctrl.pc_src = pc_jump;
      op_jal: begin
        o_ctrl.pc_src = pc_jump;
        o_ctrl.wreg   = 1'b1;
        o_ctrl.wb_src = wb_link;  // pc+4 into r31
      end
      op_cop0: begin
        case (i_inst.rs)
          c0_mf: begin
            o_ctrl.dest_rt = 1'b1;
            o_ctrl.wreg    = 1'b1;
            o_ctrl.wb_src  = wb_cp0;
            o_exc_req.mfc0 = 1'b1;
          end
          c0_mt: o_exc_req.mtc0 = 1'b1;  // rt data goes to cp0
          c0_co: begin
            if (i_inst.funct == eret_funct)
              o_exc_req.eret = 1'b1;
            else
              o_exc_req.unimpl = 1'b1;
          end
          default: o_exc_req.unimpl = 1'b1;
        endcase
      end
      default: o_exc_req.unimpl = 1'b1;  // lui, unknown opcodes
    endcase
    // a store never writes the register file
    assert (!(o_ctrl.wreg && o_ctrl.wmem))
      else $error("decoder: wreg and wmem both set");
  end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
  input  isa_pkg::alu_op_e i_op,
  input  isa_pkg::word_t   i_a,
  input  isa_pkg::word_t   i_b,
  output isa_pkg::word_t   o_y,
  output logic             o_zero,  // used by beq/bne
  output logic             o_ovf    // signed overflow on add/sub
);
  import isa_pkg::*;

  logic sa, sb, sy;  // sign bits

  always_comb begin
    case (i_op)
      alu_add: o_y = i_a + i_b;
      alu_sub: o_y = i_a - i_b;
      alu_and: o_y = i_a & i_b;
      alu_or:  o_y = i_a | i_b;
      alu_xor: o_y = i_a ^ i_b;
      default: o_y = '0;
    endcase
  end

  assign o_zero = (o_y == '0);

  assign sa = i_a[xlen-1];
  assign sb = i_b[xlen-1];
  assign sy = o_y[xlen-1];

  // add overflows when both operands share a sign the result lacks
  // sub overflows when operand signs differ and result follows b
  always_comb begin
    case (i_op)
      alu_add: o_ovf = (sa == sb) && (sy != sa);
      alu_sub: o_ovf = (sa != sb) && (sy != sa);
      default: o_ovf = 1'b0;  // logic ops never overflow
    endcase
  end

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ns

module regfile (
  input  logic               clk,
  input  logic               clrn,
  input  isa_pkg::reg_addr_t i_ra,  // rs
  input  isa_pkg::reg_addr_t i_rb,  // rt
  input  isa_pkg::reg_addr_t i_wa,
  input  logic               i_we,
  input  isa_pkg::word_t     i_wd,
  output isa_pkg::word_t     o_qa,
  output isa_pkg::word_t     o_qb
);
  import isa_pkg::*;

  word_t regs [0:nregs-1];

  // r0 is never written so it reads zero through the plain array
  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      for (int i = 0; i < nregs; i++)
        regs[i] <= '0;
    end else if (i_we && (i_wa != '0)) begin
      regs[i_wa] <= i_wd;
    end
  end

  assign o_qa = regs[i_ra];  // async reads
  assign o_qb = regs[i_rb];

  a_r0_zero: assert property (@(posedge clk) disable iff (!clrn)
    (i_ra != '0 || o_qa == '0) && (i_rb != '0 || o_qb == '0));

endmodule

/* hw/cp0.sv */
`timescale 1ns/1ns

module cp0 (
  input  logic              clk,
  input  logic              clrn,
  input  cp0_pkg::exc_req_t i_req,
  input  logic              i_ovf,      // alu signed overflow
  input  logic              i_intr,
  input  isa_pkg::word_t    i_pc,
  input  isa_pkg::word_t    i_next_pc,  // where the program goes next
  input  isa_pkg::word_t    i_wdata,    // rt data for mtc0
  output cp0_pkg::pc_sel_e  o_pc_sel,
  output isa_pkg::word_t    o_epc,
  output isa_pkg::word_t    o_rdata,    // mfc0 value
  output logic              o_inta
);
  import isa_pkg::*;
  import cp0_pkg::*;

  word_t     status, cause, epc;
  logic      take_intr, take_sys, take_unimpl, take_ovf, exc;
  exc_code_e code;

  // a source counts only when its status enable is set
  assign take_intr   = status[status_bit_intr] & i_intr;
  assign take_sys    = status[status_bit_syscall] & i_req.syscall;
  assign take_unimpl = status[status_bit_unimpl] & i_req.unimpl;
  assign take_ovf    = status[status_bit_ovf] & i_req.arith & i_ovf;
  assign exc         = take_intr | take_sys | take_unimpl | take_ovf;
  assign o_inta      = take_intr;

  always_comb begin
    if (take_intr)
      code = exc_intr;  // interrupt wins the code
    else if (take_sys)
      code = exc_syscall;
    else if (take_unimpl)
      code = exc_unimpl;
    else
      code = exc_ovf;
  end

  always_comb begin
    if (exc)
      o_pc_sel = sel_vector;
    else if (i_req.eret)
      o_pc_sel = sel_epc;
    else
      o_pc_sel = sel_next;
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      status <= '0;  // all sources masked
      cause  <= '0;
      epc    <= '0;
    end else if (exc) begin
      cause  <= word_t'(code) << cause_code_lsb;
      epc    <= take_intr ? i_next_pc : i_pc;  // interrupted instr completes
      status <= status << status_shift;        // push enables, all off
    end else if (i_req.eret) begin
      status <= status >> status_shift;  // pop enables
    end else if (i_req.mtc0) begin
      case (i_req.c0_reg)
        creg_status: status <= i_wdata;
        creg_cause:  cause  <= i_wdata;
        creg_epc:    epc    <= i_wdata;
        default:     ;  // other cp0 numbers not kept
      endcase
    end
  end

  always_comb begin
    case (i_req.c0_reg)
      creg_status: o_rdata = status;
      creg_cause:  o_rdata = cause;
      creg_epc:    o_rdata = epc;
      default:     o_rdata = '0;
    endcase
    if (!i_req.mfc0)
      o_rdata = '0;
  end

  assign o_epc = epc;

  a_inta_vector: assert property (@(posedge clk) disable iff (!clrn)
    o_inta |-> (o_pc_sel == sel_vector));

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
  input  logic           clk,
  input  logic           clrn,
  input  isa_pkg::word_t i_inst,
  input  isa_pkg::word_t i_mem,   // load data at o_alu
  input  logic           i_intr,
  output isa_pkg::word_t o_pc,
  output isa_pkg::word_t o_alu,   // result, also the memory address
  output isa_pkg::word_t o_data,  // store data
  output logic           o_wmem,
  output logic           o_inta
);
  import isa_pkg::*;
  import cp0_pkg::*;

  instr_t    inst;
  ctrl_t     ctrl;
  exc_req_t  exc_req;
  pc_sel_e   pc_sel;
  word_t     pc, pc_plus4, br_target, jmp_target, next_pc;
  word_t     imm_ext, alu_b, alu_y, qa, qb, wb_data, epc, c0_rdata;
  reg_addr_t wa;
  logic      zero, ovf;

  assign inst = instr_t'(i_inst);

  assign pc_plus4   = pc + xlen'(4);
  assign imm_ext    = {{(xlen-16){ctrl.sext & i_inst[15]}}, i_inst[15:0]};
  assign br_target  = pc_plus4 + {imm_ext[xlen-3:0], 2'b00};  // word offset
  assign jmp_target = {pc_plus4[xlen-1:xlen-4], i_inst[25:0], 2'b00};

  always_comb begin
    case (ctrl.pc_src)
      pc_branch: next_pc = br_target;
      pc_reg:    next_pc = qa;  // jr
      pc_jump:   next_pc = jmp_target;
      default:   next_pc = pc_plus4;
    endcase
  end

  // cp0 decides on redirects, only its select is applied here
  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn)
      pc <= '0;
    else begin
      case (pc_sel)
        sel_epc:    pc <= epc;
        sel_vector: pc <= exc_vector;
        default:    pc <= next_pc;
      endcase
    end
  end

  assign alu_b = ctrl.alu_imm ? imm_ext : qb;

  // jal writes r31, i-type and mfc0 write rt
  assign wa = (ctrl.wb_src == wb_link) ? reg_ra :
              ctrl.dest_rt             ? inst.rt : inst.rd;

  always_comb begin
    case (ctrl.wb_src)
      wb_mem:  wb_data = i_mem;
      wb_link: wb_data = pc_plus4;
      wb_cp0:  wb_data = c0_rdata;
      default: wb_data = alu_y;
    endcase
  end

  decoder u_decoder (
    .i_inst    (inst),
    .i_zero    (zero),
    .o_ctrl    (ctrl),
    .o_exc_req (exc_req)
  );

  alu u_alu (
    .i_op   (ctrl.alu_op),
    .i_a    (qa),
    .i_b    (alu_b),
    .o_y    (alu_y),
    .o_zero (zero),
    .o_ovf  (ovf)
  );

  regfile u_regfile (
    .clk  (clk),
    .clrn (clrn),
    .i_ra (inst.rs),
    .i_rb (inst.rt),
    .i_wa (wa),
    .i_we (ctrl.wreg),
    .i_wd (wb_data),
    .o_qa (qa),
    .o_qb (qb)
  );

  cp0 u_cp0 (
    .clk       (clk),
    .clrn      (clrn),
    .i_req     (exc_req),
    .i_ovf     (ovf),
    .i_intr    (i_intr),
    .i_pc      (pc),
    .i_next_pc (next_pc),
    .i_wdata   (qb),  // mtc0 source is rt
    .o_pc_sel  (pc_sel),
    .o_epc     (epc),
    .o_rdata   (c0_rdata),
    .o_inta    (o_inta)
  );

  assign o_pc   = pc;
  assign o_alu  = alu_y;
  assign o_data = qb;
  assign o_wmem = ctrl.wmem;

endmodule

/* tb/cpu_model.svh */
word_t m_regs [0:31];
word_t m_dmem [0:31];                       // data memory indexed by address bits 6:2
word_t m_pc, m_status, m_cause, m_epc;
word_t exp_pc, exp_alu, exp_data, exp_mem;  // what the dut should show this cycle
logic  exp_alu_valid, exp_wmem, exp_inta;

task automatic reset_model();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
    m_dmem[i] = $urandom;  // random initial memory image
  end
  m_pc     = '0;
  m_status = '0;  // every source masked
  m_cause  = '0;
  m_epc    = '0;
endtask

function automatic word_t read_cp0(input logic [4:0] num);
  case (num)
    5'd12:   return m_status;
    5'd13:   return m_cause;
    5'd14:   return m_epc;
    default: return '0;
  endcase
endfunction

// expected outputs come from the state before the step
task automatic step_model(input word_t inst, input logic intr);
  logic [5:0]  op;
  logic [4:0]  rs, rt, rd, dst;
  word_t       a, b, simm, zimm, pc4, npc, wd;
  logic [32:0] wide;  // extra bit catches signed overflow
  logic        we, arith, sys, unimpl, eret, mtc0, exc;
  logic [1:0]  code;
  op   = inst[31:26];
  rs   = inst[25:21];
  rt   = inst[20:16];
  rd   = inst[15:11];
  a    = m_regs[rs];
  b    = m_regs[rt];
  simm = {{16{inst[15]}}, inst[15:0]};
  zimm = {16'h0, inst[15:0]};
  pc4  = m_pc + 32'd4;
  npc  = pc4;
  wide = {a[31], a} + {simm[31], simm};  // addi result or lw/sw address
  dst  = rt;
  {we, arith, sys, unimpl, eret, mtc0} = '0;
  exp_mem = m_dmem[wide[6:2]];
  case (op)
    6'h00: begin
      dst   = rd;
      arith = inst[5:0] inside {6'h20, 6'h22};
      we    = arith || inst[5:0] inside {6'h24, 6'h25, 6'h26};
      case (inst[5:0])
        6'h20:   wide = {a[31], a} + {b[31], b};
        6'h22:   wide = {a[31], a} - {b[31], b};
        6'h24:   wide = {1'b0, a & b};
        6'h25:   wide = {1'b0, a | b};
        6'h26:   wide = {1'b0, a ^ b};
        6'h08:   npc = a;  // jr
        6'h0c:   sys = 1'b1;
        default: unimpl = 1'b1;
      endcase
    end
    6'h08: begin
      arith = 1'b1;
      we    = 1'b1;
    end
    6'h0c:   begin
      we   = 1'b1;
      wide = {1'b0, a & zimm};
    end
    6'h0d:   begin
      we   = 1'b1;
      wide = {1'b0, a | zimm};
    end
    6'h0e:   begin
      we   = 1'b1;
      wide = {1'b0, a ^ zimm};
    end
    6'h23:   we = 1'b1;  // lw
    6'h2b:   ;           // sw stores below
    6'h04:   npc = (a == b) ? pc4 + (simm << 2) : pc4;
    6'h05:   npc = (a != b) ? pc4 + (simm << 2) : pc4;
    6'h02:   npc = {pc4[31:28], inst[25:0], 2'b00};
    6'h03: begin
      npc = {pc4[31:28], inst[25:0], 2'b00};
      we  = 1'b1;
      dst = 5'd31;  // link register
    end
    6'h10: begin
      case (rs)
        5'h00:   we = 1'b1;  // mfc0 into rt
        5'h04:   mtc0 = 1'b1;
        5'h10: begin
          eret   = (inst[5:0] == 6'h18);
          unimpl = !eret;
        end
        default: unimpl = 1'b1;
      endcase
    end
    default: unimpl = 1'b1;
  endcase
  wd = (op == 6'h23) ? exp_mem :
       (op == 6'h03) ? pc4 :
       (op == 6'h10) ? read_cp0(rd) : wide[31:0];
  exp_pc        = m_pc;
  exp_alu       = wide[31:0];
  exp_alu_valid = (op inside {6'h08, 6'h0c, 6'h0d, 6'h0e, 6'h23, 6'h2b}) || (op == 6'h00 && we);
  exp_data      = b;
  exp_wmem      = (op == 6'h2b);
  exp_inta      = m_status[0] & intr;
  exc = exp_inta | (m_status[1] & sys) | (m_status[2] & unimpl) |
        (m_status[3] & arith & (wide[32] ^ wide[31]));
  if (exp_inta)
    code = 2'd0;  // interrupt first
  else if (m_status[1] & sys)
    code = 2'd1;
  else if (m_status[2] & unimpl)
    code = 2'd2;
  else
    code = 2'd3;
  // a trapping instruction still does its own writes
  if (we && dst != 5'd0)
    m_regs[dst] = wd;
  if (exp_wmem)
    m_dmem[wide[6:2]] = b;
  if (exc) begin
    m_cause  = {28'h0, code, 2'b00};
    m_epc    = exp_inta ? npc : m_pc;  // interrupted instr has completed
    m_status = m_status << 4;
    m_pc     = 32'h8;
  end else if (eret) begin
    m_status = m_status >> 4;
    m_pc     = m_epc;
  end else begin
    if (mtc0) begin
      case (rd)
        5'd12:   m_status = b;
        5'd13:   m_cause  = b;
        5'd14:   m_epc    = b;
        default: ;
      endcase
    end
    m_pc = npc;
  end
endtask

/* tb/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;
  import isa_pkg::*;

  localparam int          period       = 40;
  localparam int          reset_cycles = 3;
  localparam int          n_inst       = 3000;
  localparam int          time_limit   = (2 * n_inst + reset_cycles + 2) * period;
  localparam logic [31:0] rand_seed    = 32'hbfc934a2;

  localparam logic [5:0] alu_funct [5] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26};
  localparam logic [5:0] imm_op [4]    = '{6'h08, 6'h0c, 6'h0d, 6'h0e};

  logic  clk, clrn, i_intr, o_wmem, o_inta;
  word_t i_inst, i_mem, o_pc, o_alu, o_data;
  word_t inst;  // instruction of the current cycle
  logic  intr;

  `include "cpu_model.svh"

  cpu_top i_cpu_top (
    .clk    (clk),
    .clrn   (clrn),
    .i_inst (i_inst),
    .i_mem  (i_mem),
    .i_intr (i_intr),
    .o_pc   (o_pc),
    .o_alu  (o_alu),
    .o_data (o_data),
    .o_wmem (o_wmem),
    .o_inta (o_inta)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input word_t got, input word_t want);
    assert (got === want)
      else abort_run($sformatf("error: time %0t %s got %h expected %h",
                               $time, name, got, want));
  endtask

  // weighted mix of kept instructions and some dropped patterns
  function automatic word_t random_inst();
    int unsigned pick;
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm;
    pick = $urandom_range(99, 0);
    rs   = 5'($urandom_range(7, 0));  // few registers so results get reused
    rt   = 5'($urandom_range(7, 0));
    rd   = 5'($urandom_range(7, 0));
    imm  = 16'($urandom);
    if (pick < 25)
      return {6'h00, rs, rt, rd, 5'h0, alu_funct[3'($urandom_range(4, 0))]};
    if (pick < 40)
      return {imm_op[2'($urandom_range(3, 0))], rs, rt, imm};
    if (pick < 48)
      return {6'h23, rs, rt, imm};  // lw
    if (pick < 55)
      return {6'h2b, rs, rt, imm};  // sw
    if (pick < 61)
      return {5'b00010, 1'($urandom_range(1, 0)), rs, rt, imm};  // beq bne
    if (pick < 64)
      return {5'b00001, 1'($urandom_range(1, 0)), 26'($urandom)};  // j jal
    if (pick < 66)
      return {6'h00, (pick == 64) ? 5'd31 : rs, 15'h0, 6'h08};  // jr
    if (pick < 74)
      return {6'h10, 5'h04, rt, (pick < 71) ? 5'd12 : 5'(13 + pick[0]), 11'h0};  // mtc0
    if (pick < 81)
      return {6'h10, 5'h00, rt, 5'(12 + pick % 3), 11'h0};  // mfc0
    if (pick < 85)
      return {6'h10, 5'h10, 15'h0, 6'h18};  // eret
    if (pick < 89)
      return {6'h00, 20'h0, 6'h0c};  // syscall
    if (pick < 93)
      return {6'h0f, 26'($urandom)};  // lui is not kept
    if (pick < 97)
      return {6'h00, rs, rt, rd, 5'($urandom), 6'h00};  // sll is not kept
    return {6'h10, 5'h01, 21'($urandom)};  // unknown cop0 sub-op
  endfunction

  initial begin
    void'($urandom(rand_seed));
    reset_model();
    clrn   = 1'b0;
    i_inst = '0;
    i_mem  = '0;
    i_intr = 1'b1;  // pending request while every enable is off
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    compare("o_pc", o_pc, '0);
    compare("o_inta", word_t'(o_inta), '0);
    clrn = 1'b1;  // first instruction goes in on this same edge
    for (int n = 0; n < n_inst; n++) begin
      inst = random_inst();
      intr = $urandom_range(99, 0) < 6;  // occasional interrupt pulse
      step_model(inst, intr);
      i_inst = inst;
      i_intr = intr;
      i_mem  = exp_mem;  // load data at the model's address
      #19;
      compare("o_pc", o_pc, exp_pc);
      if (exp_alu_valid)
        compare("o_alu", o_alu, exp_alu);
      compare("o_data", o_data, exp_data);
      compare("o_wmem", word_t'(o_wmem), word_t'(exp_wmem));
      compare("o_inta", word_t'(o_inta), word_t'(exp_inta));
      @(negedge clk);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(time_limit);
    abort_run("timeout: the instruction loop did not finish in time");
  end

endmodule

/* sources.f */
+incdir+tb
hw/isa_pkg.sv
hw/cp0_pkg.sv
hw/decoder.sv
hw/alu.sv
hw/regfile.sv
hw/cp0.sv
hw/cpu_top.sv
tb/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build the cpu testbench with verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cpu -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
